// ==== src/tcb_memory.sv ====
`timescale 1ns/10ps

module tcb_memory
    import tcb_pkg::*;
#(
    parameter int unsigned DEPTH = 256
)(
    input  logic     sub,
    input  logic     rst_n,
    input  logic     vld,
    input  tcb_req_t req,
    output logic     rdy,
    output tcb_rsp_t rsp
);

    //////////////////////////////////////////////////////////////////////
    // local declarations
    //////////////////////////////////////////////////////////////////////

    // word index width
    localparam int unsigned AW = $clog2(DEPTH);

    // idle accepts requests, merge finishes a partial write
    typedef enum logic {
        idle,
        merge
    } state_e;

    state_e state;

    // word storage
    logic [tcb_dat_w-1:0] mem [DEPTH];

    // request decode
    logic [AW-1:0]        idx;
    logic [tcb_off_w-1:0] off;
    logic [tcb_byt_n-1:0] msk;
    logic                 err;
    logic                 trn;
    logic                 wr;
    logic                 wr_full;
    logic                 rmw_start;

    // read port register, also the old word for a merge
    logic [tcb_dat_w-1:0] rd_dat;

    // partial write held for the merge cycle
    logic [AW-1:0]        rmw_idx;
    logic [tcb_byt_n-1:0] rmw_msk;
    logic [tcb_dat_w-1:0] rmw_wdt;
    logic [tcb_dat_w-1:0] rmw_new;

    // response
    logic                 rsp_vld;
    logic                 rsp_err;
    // writes and failed reads return zero data
    logic                 rsp_clr;

    //////////////////////////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////////////////////////

    // upper address bits dropped, so accesses wrap modulo DEPTH words
    assign idx = req.adr[tcb_off_w +: AW];
    assign off = req.adr[tcb_off_w-1:0];
    assign msk = tcb_mask(req.siz, off);

    // alignment check
    always_comb begin
        case (req.siz)
            siz_byte: err = 1'b0;
            siz_half: err = off[0];
            siz_word: err = (off != '0);
            default:  err = 1'b1;
        endcase
    end

    assign rdy = (state == idle);
    assign trn = vld & rdy;

    // misaligned writes never touch the array
    assign wr        = trn & (req.op == op_write) & ~err;
    assign wr_full   = wr & (msk == '1);
    assign rmw_start = wr & (msk != '1);

    //////////////////////////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////////////////////////

    // merge lasts exactly one cycle
    always_ff @(posedge sub or negedge rst_n) begin
        if (!rst_n) begin
            state   <= idle;
            rsp_vld <= 1'b0;
        end else begin
            state   <= rmw_start ? merge : idle;
            rsp_vld <= trn;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // array access
    //////////////////////////////////////////////////////////////////////

    // new bytes over old word
    always_comb begin
        rmw_new = rd_dat;
        for (int i = 0; i < tcb_byt_n; i++) begin
            if (rmw_msk[i]) begin
                rmw_new[i*8 +: 8] = rmw_wdt[i*8 +: 8];
            end
        end
    end

    // single port, read on transfer, write on transfer or merge
    always_ff @(posedge sub) begin
        if (trn) begin
            rd_dat  <= mem[idx];
            rsp_err <= err;
            rsp_clr <= (req.op == op_write) | err;
        end
        if (rmw_start) begin
            rmw_idx <= idx;
            rmw_msk <= msk;
            rmw_wdt <= req.wdt;
        end
        if (wr_full) begin
            mem[idx] <= req.wdt;
        end else if (state == merge) begin
            mem[rmw_idx] <= rmw_new;
        end
    end

    // whole word, manager picks its bytes
    assign rsp.vld = rsp_vld;
    assign rsp.rdt = rsp_clr ? '0 : rd_dat;
    assign rsp.err = rsp_err;

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    // partial write blocks the next cycle
    a_rmw_block: assert property (@(posedge sub) disable iff (!rst_n)
        rmw_start |=> !rdy ##1 rdy);

    a_rsp_known: assert property (@(posedge sub) disable iff (!rst_n)
        !$isunknown(rsp.vld));

endmodule

// ==== src/tcb_pkg.sv ====
package tcb_pkg;

    //////////////////////////////////////////////////////////////////////
    // bus geometry
    //////////////////////////////////////////////////////////////////////

    // byte address
    localparam int unsigned tcb_adr_w = 16;
    // data bus
    localparam int unsigned tcb_dat_w = 32;
    // bytes per word
    localparam int unsigned tcb_byt_n = tcb_dat_w / 8;
    // address bits that select a byte inside a word
    localparam int unsigned tcb_off_w = $clog2(tcb_byt_n);

    //////////////////////////////////////////////////////////////////////
    // encodings
    //////////////////////////////////////////////////////////////////////

    // logarithmic transfer size, 2**siz bytes
    typedef enum logic [1:0] {
        siz_byte = 2'd0,
        siz_half = 2'd1,
        siz_word = 2'd2
    } tcb_siz_e;

    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } tcb_op_e;

    //////////////////////////////////////////////////////////////////////
    // request and response
    //////////////////////////////////////////////////////////////////////

    // write data sits in the byte lanes picked by the address
    typedef struct packed {
        tcb_op_e                op;
        logic [tcb_adr_w-1:0]   adr;
        tcb_siz_e               siz;
        logic [tcb_dat_w-1:0]   wdt;
    } tcb_req_t;

    // one-cycle vld pulse per request
    typedef struct packed {
        logic                   vld;
        logic [tcb_dat_w-1:0]   rdt;
        logic                   err;
    } tcb_rsp_t;

    // byte lanes touched by a transfer of size siz at byte offset off
    function automatic logic [tcb_byt_n-1:0] tcb_mask(
        input tcb_siz_e             siz,
        input logic [tcb_off_w-1:0] off
    );
        case (siz)
            siz_byte: return tcb_byt_n'(1) << off;
            siz_half: return tcb_byt_n'(3) << off;
            siz_word: return '1;
            default:  return '0;
        endcase
    endfunction

endpackage

// ==== src/tcb_register_backpressure.sv ====
`timescale 1ns/10ps

module tcb_register_backpressure
    import tcb_pkg::*;
(
    input  logic     sub,
    input  logic     rst_n,
    // subordinate side, manager connects here
    input  logic     sub_vld,
    input  tcb_req_t sub_req,
    output logic     sub_rdy,
    // manager side, subordinate connects here
    output logic     man_vld,
    output tcb_req_t man_req,
    input  logic     man_rdy
);

    //////////////////////////////////////////////////////////////////////
    // local declarations
    //////////////////////////////////////////////////////////////////////

    // request parked while the memory stalls
    tcb_req_t             buf_req;
    // byte lanes the incoming size covers
    logic [tcb_byt_n-1:0] buf_msk;
    // accepted here but not downstream
    logic                 park;

    //////////////////////////////////////////////////////////////////////
    // ready register
    //////////////////////////////////////////////////////////////////////

    assign buf_msk = tcb_mask(sub_req.siz, sub_req.adr[tcb_off_w-1:0]);
    assign park    = sub_vld & sub_rdy & ~man_rdy;

    // low exactly while the buffer holds a request
    always_ff @(posedge sub or negedge rst_n) begin
        if (!rst_n) begin
            sub_rdy <= 1'b1;
        end else if (sub_rdy) begin
            sub_rdy <= ~park;
        end else begin
            sub_rdy <= man_rdy;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // buffer
    //////////////////////////////////////////////////////////////////////

    // only covered write lanes toggle
    always_ff @(posedge sub) begin
        if (park) begin
            buf_req.op  <= sub_req.op;
            buf_req.adr <= sub_req.adr;
            buf_req.siz <= sub_req.siz;
            for (int i = 0; i < tcb_byt_n; i++) begin
                if (buf_msk[i]) begin
                    buf_req.wdt[i*8 +: 8] <= sub_req.wdt[i*8 +: 8];
                end
            end
        end
    end

    // straight through while ready, buffer otherwise
    assign man_vld = sub_rdy ? sub_vld : 1'b1;
    assign man_req = sub_rdy ? sub_req : buf_req;

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    // a held request is a captured one
    a_hold_vld: assert property (@(posedge sub) disable iff (!rst_n)
        !sub_rdy |-> man_vld && !$isunknown({man_req.op, man_req.adr, man_req.siz}));

endmodule

// ==== src/tcb_response_pipe.sv ====
`timescale 1ns/10ps

module tcb_response_pipe
    import tcb_pkg::*;
#(
    parameter int unsigned DLY = 2
)(
    input  logic     sub,
    input  logic     rst_n,
    input  tcb_rsp_t din,
    output tcb_rsp_t dout
);

    //////////////////////////////////////////////////////////////////////
    // delay line, DLY-1 stages
    //////////////////////////////////////////////////////////////////////

    generate
        if (DLY == 1) begin: g_wire
            // memory already gives the one cycle
            assign dout = din;
        end else begin: g_shift
            // stage valids
            logic [DLY-2:0]       vld_q;
            // stage payload
            logic [tcb_dat_w-1:0] rdt_q [DLY-1];
            logic [DLY-2:0]       err_q;

            always_ff @(posedge sub or negedge rst_n) begin
                if (!rst_n) begin
                    vld_q <= '0;
                end else begin
                    vld_q[0] <= din.vld;
                    for (int i = 1; i < DLY - 1; i++) begin
                        vld_q[i] <= vld_q[i-1];
                    end
                end
            end

            // payload only moves with a valid, idle stages keep still
            always_ff @(posedge sub) begin
                if (din.vld) begin
                    rdt_q[0] <= din.rdt;
                    err_q[0] <= din.err;
                end
                for (int i = 1; i < DLY - 1; i++) begin
                    if (vld_q[i-1]) begin
                        rdt_q[i] <= rdt_q[i-1];
                        err_q[i] <= err_q[i-1];
                    end
                end
            end

            // last stage
            assign dout.vld = vld_q[DLY-2];
            assign dout.rdt = rdt_q[DLY-2];
            assign dout.err = err_q[DLY-2];
        end
    endgenerate

    a_dout_known: assert property (@(posedge sub) disable iff (!rst_n)
        !$isunknown(dout.vld));

endmodule

// ==== src/tcb_system.sv ====
`timescale 1ns/10ps

module tcb_system
    import tcb_pkg::*;
#(
    parameter int unsigned DLY   = 2,
    parameter int unsigned DEPTH = 256
)(
    input  logic     sub,
    input  logic     rst_n,
    // manager request
    input  logic     req_vld,
    input  tcb_req_t req,
    output logic     req_rdy,
    // response, DLY cycles after transfer when nothing stalls
    output tcb_rsp_t rsp
);

    //////////////////////////////////////////////////////////////////////
    // internal wires
    //////////////////////////////////////////////////////////////////////

    // slice to memory
    logic     man_vld;
    tcb_req_t man_req;
    logic     man_rdy;

    // memory to response pipe
    tcb_rsp_t mem_rsp;

    //////////////////////////////////////////////////////////////////////
    // instances
    //////////////////////////////////////////////////////////////////////

    // registered ready toward the manager
    tcb_register_backpressure u_slice (
        .sub     (sub),
        .rst_n   (rst_n),
        .sub_vld (req_vld),
        .sub_req (req),
        .sub_rdy (req_rdy),
        .man_vld (man_vld),
        .man_req (man_req),
        .man_rdy (man_rdy)
    );

    // word memory, stalls one cycle on partial writes
    tcb_memory #(
        .DEPTH (DEPTH)
    ) u_mem (
        .sub   (sub),
        .rst_n (rst_n),
        .vld   (man_vld),
        .req   (man_req),
        .rdy   (man_rdy),
        .rsp   (mem_rsp)
    );

    // remaining DLY-1 cycles
    tcb_response_pipe #(
        .DLY (DLY)
    ) u_rsp (
        .sub   (sub),
        .rst_n (rst_n),
        .din   (mem_rsp),
        .dout  (rsp)
    );

endmodule

// ==== tcb_system.f ====
src/tcb_pkg.sv
src/tcb_register_backpressure.sv
src/tcb_memory.sv
src/tcb_response_pipe.sv
src/tcb_system.sv
test/tcb_system_tb.sv

// ==== test/tcb_stim.txt ====
# op adr siz wdt exp_rdt exp_err gap (adr wdt exp_rdt in hex, the rest decimal)
# op 1=write 0=read, siz 0=byte 1=half 2=word, gap -1 picks a random idle count
1 0000 2 11223344 00000000 0 0
1 0004 2 55667788 00000000 0 0
1 0008 2 99aabbcc 00000000 0 0
0 0000 2 00000000 11223344 0 0
0 0004 2 00000000 55667788 0 0
0 0008 2 00000000 99aabbcc 0 2
1 0001 0 0000ee00 00000000 0 3
0 0000 2 00000000 1122ee44 0 3
1 0006 1 abcd0000 00000000 0 3
0 0004 2 00000000 abcd7788 0 -1
0 0003 0 00000000 1122ee44 0 -1
1 0008 0 000000dd 00000000 0 0
1 0009 0 00005500 00000000 0 0
0 0008 2 00000000 99aa55dd 0 0
1 000a 1 12340000 00000000 0 0
0 0008 2 00000000 123455dd 0 0
0 0000 2 00000000 1122ee44 0 0
1 000c 2 cafef00d 00000000 0 0
0 000c 2 00000000 cafef00d 0 4
1 0002 2 deadbeef 00000000 1 0
1 0005 1 00ffff00 00000000 1 0
0 0005 1 00000000 00000000 1 0
0 0001 2 00000000 00000000 1 0
0 0000 2 00000000 1122ee44 0 2
0 0004 2 00000000 abcd7788 0 -1
1 0410 2 0f0e0d0c 00000000 0 1
0 0010 2 00000000 0f0e0d0c 0 -1
1 0812 1 77660000 00000000 0 0
0 fc10 2 00000000 77660d0c 0 2
0 000c 2 00000000 cafef00d 0 10
1 0020 2 a5a5a5a5 00000000 0 10
0 0020 2 00000000 a5a5a5a5 0 10
0 0008 2 00000000 123455dd 0 -1

// ==== test/tcb_system_tb.sv ====
`timescale 1ns/10ps

module tcb_system_tb
    import tcb_pkg::*;
();

    //////////////////////////////////////////////////////////////////////
    // setup
    //////////////////////////////////////////////////////////////////////

    localparam int unsigned DLY     = 2;
    localparam int unsigned DEPTH   = 256;
    localparam int unsigned RST_CYC = 4;
    // random idle counts stay below this
    localparam int unsigned RND_GAP = 8;

    // one outstanding response
    typedef struct packed {
        logic [31:0] rdt;
        logic        err;
        logic [15:0] line;
        logic [31:0] cyc;
        logic        timed;
    } exp_t;

    logic     sub;
    logic     rst_n;
    logic     req_vld;
    tcb_req_t req;
    logic     req_rdy;
    tcb_rsp_t rsp;

    // stimulus table, one entry per data line
    tcb_req_t    stim_req  [$];
    logic [31:0] stim_rdt  [$];
    logic        stim_err  [$];
    int          stim_gap  [$];
    int          stim_line [$];

    // expected responses in issue order
    exp_t exp_q [$];

    int          errors;
    int          checks;
    int          cyc;
    int          max_gap;
    // cycle of the last aligned partial write
    int          part_cyc;
    logic        stall_seen;
    logic        loaded;
    logic [31:0] rnd;

    tcb_system #(
        .DLY   (DLY),
        .DEPTH (DEPTH)
    ) u_dut (
        .sub     (sub),
        .rst_n   (rst_n),
        .req_vld (req_vld),
        .req     (req),
        .req_rdy (req_rdy),
        .rsp     (rsp)
    );

    initial begin
        sub = 1'b0;
        forever #5 sub = ~sub;
    end

    // cycle count, read only on falling edges
    always @(posedge sub) begin
        cyc <= cyc + 1;
    end

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAIL %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic finish_run();
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    endtask

    // comment lines and short lines are skipped
    task automatic load_stim();
        int          fd;
        int          n;
        int          num;
        int          siz;
        int          err;
        int          gap;
        string       line;
        logic [31:0] op;
        logic [31:0] adr;
        logic [31:0] wdt;
        logic [31:0] rdt;
        tcb_req_t    r;
        num     = 0;
        max_gap = RND_GAP - 1;
        fd      = $fopen("test/tcb_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open stimulus file test/tcb_stim.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            num++;
            if (line.len() == 0 || line[0] == "#") continue;
            n = $sscanf(line, "%h %h %d %h %h %d %d", op, adr, siz, wdt, rdt, err, gap);
            if (n != 7) continue;
            r.op  = tcb_op_e'(op[0]);
            r.adr = adr[tcb_adr_w-1:0];
            r.siz = tcb_siz_e'(siz[1:0]);
            r.wdt = wdt;
            stim_req.push_back(r);
            stim_rdt.push_back(rdt);
            stim_err.push_back(err[0]);
            stim_gap.push_back(gap);
            stim_line.push_back(num);
            if (gap > max_gap) max_gap = gap;
        end
        $fclose(fd);
    endtask

    //////////////////////////////////////////////////////////////////////
    // driver
    //////////////////////////////////////////////////////////////////////

    // entered 1 ns after a rising edge
    task automatic drive_req(input int i);
        int   gap;
        exp_t e;
        req_vld = 1'b1;
        req     = stim_req[i];
        @(negedge sub);
        // memory only stalls right after a partial write
        if (cyc - part_cyc > 3) begin
            check_value($sformatf("line %0d ready", stim_line[i]), 1, req_rdy);
        end
        while (!req_rdy) begin
            @(negedge sub);
        end
        // transfer on the coming edge
        e.rdt   = stim_rdt[i];
        e.err   = stim_err[i];
        e.line  = 16'(stim_line[i]);
        e.cyc   = cyc;
        // nothing in flight, so the latency is fixed
        e.timed = (exp_q.size() == 0) && (rsp.vld === 1'b0);
        exp_q.push_back(e);
        if (stim_req[i].op == op_write && stim_req[i].siz != siz_word && !stim_err[i]) begin
            part_cyc = cyc;
        end
        @(posedge sub);
        #1;
        req_vld = 1'b0;
        req     = '0;
        gap     = stim_gap[i];
        if (gap < 0) begin
            rnd = xorshift32(rnd);
            gap = rnd % RND_GAP;
        end
        repeat (gap) begin
            @(posedge sub);
            #1;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // response monitor
    //////////////////////////////////////////////////////////////////////

    always @(negedge sub) begin : monitor
        exp_t e;
        if (rst_n === 1'b1) begin
            if (!req_rdy) stall_seen = 1'b1;
            if (rsp.vld === 1'b1) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("response arrived with no request outstanding");
                end else begin
                    e = exp_q.pop_front();
                    check_value($sformatf("line %0d rdt", e.line), e.rdt, rsp.rdt);
                    check_value($sformatf("line %0d err", e.line), e.err, rsp.err);
                    if (e.timed) begin
                        check_value($sformatf("line %0d latency", e.line), DLY, cyc - e.cyc);
                    end
                end
            end else if (rsp.vld !== 1'b0) begin
                errors++;
                $display("response valid is unknown at cycle %0d", cyc);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // sequence and watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin : main
        rst_n      = 1'b0;
        req_vld    = 1'b0;
        req        = '0;
        errors     = 0;
        checks     = 0;
        cyc        = 0;
        // far enough back that the first requests see no stall
        part_cyc   = -8;
        stall_seen = 1'b0;
        loaded     = 1'b0;
        rnd        = 32'h9128e803;
        load_stim();
        loaded = 1'b1;
        if (stim_req.size() == 0) begin
            $display("no transactions were read from the stimulus file");
            errors++;
            finish_run();
        end else begin
            repeat (RST_CYC) @(posedge sub);
            #1;
            rst_n = 1'b1;
            for (int i = 0; i < stim_req.size(); i++) begin
                drive_req(i);
            end
            wait (exp_q.size() == 0);
            // catch any extra response
            repeat (DLY + 4) @(posedge sub);
            // partial writes must have stalled the slice somewhere
            check_value("backpressure seen", 1, stall_seen);
            finish_run();
        end
    end

    initial begin : watchdog
        int limit;
        wait (loaded);
        limit = stim_req.size() * (max_gap + DLY + 4) + RST_CYC;
        repeat (limit) @(posedge sub);
        errors++;
        $display("timeout after %0d cycles with %0d responses missing", limit, exp_q.size());
        finish_run();
    end

endmodule
